/* compile.f */
+incdir+.
arb_pkg.sv
write_grant_fsm.sv
channel_forwarder.sv
quantum_timer.sv
axi_lite_write_arbiter.sv
arb_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the arbiter testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --top-module arb_tb -f compile.f -o arb_sim \
    && ./obj_dir/arb_sim > sim.log 2>&1
cat sim.log 2>/dev/null

grep -q "Verification passed" sim.log && echo "Simulation PASSED" \
    || { echo "Simulation FAILED"; exit 1; }

/* arb_tb_tasks.svh */
`ifndef ARB_TB_TASKS_SVH
`define ARB_TB_TASKS_SVH

////////////////////////////////////////////////////////////////////////////
// Compare tasks
////////////////////////////////////////////////////////////////////////////

task automatic check_aw(input arb_pkg::aw_payload_t got, input arb_pkg::aw_payload_t exp,
                        input string what);
    if (got !== exp) begin
        abort_run($sformatf("FAIL at %0d ns: %s addr %h prot %h, expected addr %h prot %h",
                            $time, what, got.addr, got.prot, exp.addr, exp.prot));
    end
endtask

task automatic check_w(input arb_pkg::w_payload_t got, input arb_pkg::w_payload_t exp,
                       input string what);
    if (got !== exp) begin
        abort_run($sformatf("FAIL at %0d ns: %s data %h strb %h, expected data %h strb %h",
                            $time, what, got.data, got.strb, exp.data, exp.strb));
    end
endtask

task automatic check_idx(input arb_pkg::master_idx_t got, input arb_pkg::master_idx_t exp,
                         input string what);
    if (got !== exp) begin
        abort_run($sformatf("FAIL at %0d ns: %s is %0d, expected %0d", $time, what, got, exp));
    end
endtask

task automatic check_mask(input arb_pkg::master_mask_t got, input arb_pkg::master_mask_t exp,
                          input string what);
    if (got !== exp) begin
        abort_run($sformatf("FAIL at %0d ns: %s is %b, expected %b", $time, what, got, exp));
    end
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        abort_run($sformatf("FAIL at %0d ns: %s is %b, expected %b", $time, what, got, exp));
    end
endtask

task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
        abort_run($sformatf("FAIL at %0d ns: %s is %0d, expected %0d", $time, what, got, exp));
    end
endtask

task automatic check_reset_outputs(input string phase);
    check_mask(m_awready, '0, {"master AW ready ", phase});
    check_mask(m_wready, '0, {"master W ready ", phase});
    check_mask(m_bvalid, '0, {"master B valid ", phase});
    check_bit(s_awvalid, 1'b0, {"slave AW valid ", phase});
    check_bit(s_wvalid, 1'b0, {"slave W valid ", phase});
    check_bit(s_bready, 1'b0, {"slave B ready ", phase});
endtask

////////////////////////////////////////////////////////////////////////////
// Timed waits and master driver
////////////////////////////////////////////////////////////////////////////

task automatic wait_grant_idle(input int limit);
    bit idle;
    int waited;
    idle   = 1'b0;
    waited = 0;
    while (!idle) begin
        #(SAMPLE_DLY);
        idle = !dut0.grant_active;
        @(negedge clk);
        waited++;
        if (!idle && waited > limit) begin
            abort_run("Timed out waiting for the arbiter to return to idle");
        end
    end
endtask

// One write per call, valids held until the whole write completes
task automatic drive_write(input arb_pkg::master_idx_t idx, input arb_pkg::aw_payload_t aw,
                           input arb_pkg::w_payload_t w, input bit expect_b);
    bit aw_ok;
    bit w_ok;
    bit b_ok;
    int held;
    int waited;
    aw_ok  = 1'b0;
    w_ok   = 1'b0;
    b_ok   = 1'b0;
    held   = 0;
    waited = 0;
    @(negedge clk);
    m_awpayload[idx] = aw;
    m_awvalid[idx]   = 1'b1;
    m_wpayload[idx]  = w;
    m_wvalid[idx]    = 1'b1;
    m_bready[idx]    = expect_b;
    while (!(aw_ok && w_ok && b_ok)) begin
        #(SAMPLE_DLY);
        aw_ok = aw_ok | m_awready[idx];
        w_ok  = w_ok | m_wready[idx];
        if (expect_b) begin
            b_ok = b_ok | m_bvalid[idx];
        end else if (aw_ok && w_ok) begin
            held++;
            b_ok = (held > HOLD_CYCLES); // Slave ready again while the valids stay up
        end
        @(negedge clk);
        waited++;
        if (waited > WAIT_LIMIT) begin
            abort_run($sformatf("Master %0d timed out waiting for its write", idx));
        end
    end
    m_awvalid[idx] = 1'b0;
    m_wvalid[idx]  = 1'b0;
    m_bready[idx]  = 1'b0;
endtask

`endif

/* arb_tb.sv */
`include "arb_macros.svh"

module arb_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD  = 8;
    localparam int SAMPLE_DLY  = 3;  // Just before the rising edge
    localparam int WAIT_LIMIT  = 200;
    localparam int NUM_RANDOM  = 24;
    localparam int HOLD_CYCLES = 4;  // Longer than the slave's longest ready delay

    typedef arb_pkg::master_idx_t idx_list_t[$];

    logic clk = 1'b0;
    logic resetn;

    arb_pkg::master_mask_t                        m_awvalid;
    arb_pkg::master_mask_t                        m_awready;
    arb_pkg::aw_payload_t [`ARB_NUM_MASTERS-1:0]  m_awpayload;
    arb_pkg::master_mask_t                        m_wvalid;
    arb_pkg::master_mask_t                        m_wready;
    arb_pkg::w_payload_t [`ARB_NUM_MASTERS-1:0]   m_wpayload;
    arb_pkg::master_mask_t                        m_bvalid;
    arb_pkg::master_mask_t                        m_bready;
    logic                                         s_awvalid;
    logic                                         s_awready = 1'b0;
    arb_pkg::aw_payload_t                         s_awpayload;
    logic                                         s_wvalid;
    logic                                         s_wready = 1'b0;
    arb_pkg::w_payload_t                          s_wpayload;
    logic                                         s_bvalid = 1'b0;
    logic                                         s_bready;

    // Expected traffic of the running batch
    idx_list_t             exp_aw_q;
    idx_list_t             exp_w_q;
    arb_pkg::aw_payload_t  exp_aw_pl [`ARB_NUM_MASTERS];
    arb_pkg::w_payload_t   exp_w_pl [`ARB_NUM_MASTERS];
    arb_pkg::master_mask_t batch_mask;
    arb_pkg::master_mask_t bvalid_seen;
    int                    aw_count [`ARB_NUM_MASTERS];
    int                    w_count [`ARB_NUM_MASTERS];
    int                    b_count [`ARB_NUM_MASTERS];
    int                    aw_cycle [`ARB_NUM_MASTERS];
    int                    cycle_no = 0;
    int                    gap;

    // Slave model state
    logic withhold_b;
    logic hold_b = 1'b0;
    logic run_s = 1'b0;
    logic aw_hs_s = 1'b0;
    logic w_hs_s = 1'b0;
    logic b_hs_s = 1'b0;
    bit   aw_got;
    bit   w_got;
    bit   b_pend;
    int   aw_wait;
    int   w_wait;
    int   b_wait;

    always #(CLK_PERIOD / 2) clk = ~clk;

    axi_lite_write_arbiter dut0 (
        .clk           (clk),
        .resetn        (resetn),
        .i_m_awvalid   (m_awvalid),
        .o_m_awready   (m_awready),
        .i_m_awpayload (m_awpayload),
        .i_m_wvalid    (m_wvalid),
        .o_m_wready    (m_wready),
        .i_m_wpayload  (m_wpayload),
        .o_m_bvalid    (m_bvalid),
        .i_m_bready    (m_bready),
        .o_s_awvalid   (s_awvalid),
        .i_s_awready   (s_awready),
        .o_s_awpayload (s_awpayload),
        .o_s_wvalid    (s_wvalid),
        .i_s_wready    (s_wready),
        .o_s_wpayload  (s_wpayload),
        .i_s_bvalid    (s_bvalid),
        .o_s_bready    (s_bready)
    );

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Verification failed");
        $fatal(1, "Stopped at the first error");
    endtask

    `include "arb_tb_tasks.svh"

    // Ascending list of requesting indices
    function automatic idx_list_t expected_order(input arb_pkg::master_mask_t req);
        idx_list_t order;
        for (int i = 0; i < `ARB_NUM_MASTERS; i++) begin
            if (req[i]) begin
                order.push_back(arb_pkg::master_idx_t'(i));
            end
        end
        return order;
    endfunction

    function automatic arb_pkg::master_idx_t ready_source(input arb_pkg::master_mask_t mask);
        arb_pkg::master_idx_t idx;
        idx = '0;
        for (int i = 0; i < `ARB_NUM_MASTERS; i++) begin
            if (mask[i]) begin
                idx = arb_pkg::master_idx_t'(i);
            end
        end
        return idx;
    endfunction

    function automatic arb_pkg::aw_payload_t random_aw();
        logic [63:0] r;
        r = {$urandom, $urandom};
        return r[$bits(arb_pkg::aw_payload_t)-1:0];
    endfunction

    function automatic arb_pkg::w_payload_t random_w();
        logic [63:0] r;
        r = {$urandom, $urandom};
        return r[$bits(arb_pkg::w_payload_t)-1:0];
    endfunction

    task automatic run_batch(input arb_pkg::master_mask_t req, input bit expect_b);
        for (int i = 0; i < `ARB_NUM_MASTERS; i++) begin
            exp_aw_pl[i] = random_aw();
            exp_w_pl[i]  = random_w();
            aw_count[i]  = 0;
            w_count[i]   = 0;
            b_count[i]   = 0;
        end
        exp_aw_q    = expected_order(req);
        exp_w_q     = expected_order(req);
        batch_mask  = req;
        bvalid_seen = '0;
        fork
            if (req[0]) drive_write(2'd0, exp_aw_pl[0], exp_w_pl[0], expect_b);
            if (req[1]) drive_write(2'd1, exp_aw_pl[1], exp_w_pl[1], expect_b);
            if (req[2]) drive_write(2'd2, exp_aw_pl[2], exp_w_pl[2], expect_b);
        join
        wait_grant_idle(WAIT_LIMIT);
        for (int i = 0; i < `ARB_NUM_MASTERS; i++) begin
            check_count(aw_count[i], int'(req[i]), $sformatf("AW count of master %0d", i));
            check_count(w_count[i], int'(req[i]), $sformatf("W count of master %0d", i));
            check_count(b_count[i], expect_b ? int'(req[i]) : 0,
                        $sformatf("B count of master %0d", i));
        end
        check_count(exp_aw_q.size(), 0, "AW transfers still missing");
        check_count(exp_w_q.size(), 0, "W transfers still missing");
        batch_mask = '0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Slave model
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (!run_s) begin
            s_awready = 1'b0;
            s_wready  = 1'b0;
            s_bvalid  = 1'b0;
            aw_got    = 1'b0;
            w_got     = 1'b0;
            b_pend    = 1'b0;
            aw_wait   = $urandom_range(3, 0);
            w_wait    = $urandom_range(3, 0);
        end else begin
            if (aw_hs_s) begin
                aw_got    = 1'b1;
                s_awready = 1'b0;
            end
            if (w_hs_s) begin
                w_got    = 1'b1;
                s_wready = 1'b0;
            end
            if (b_hs_s) begin
                s_bvalid = 1'b0;
                b_pend   = 1'b0;
                aw_got   = 1'b0;
                w_got    = 1'b0;
                aw_wait  = $urandom_range(3, 0);
                w_wait   = $urandom_range(3, 0);
            end else if (aw_got && w_got && !b_pend) begin
                if (hold_b) begin
                    aw_got  = 1'b0; // Response dropped and the next write taken
                    w_got   = 1'b0;
                    aw_wait = $urandom_range(3, 0);
                    w_wait  = $urandom_range(3, 0);
                end else begin
                    b_pend = 1'b1;
                    b_wait = $urandom_range(2, 0);
                end
            end
            if (b_pend && !s_bvalid) begin
                if (b_wait == 0) begin
                    s_bvalid = 1'b1;
                end else begin
                    b_wait--;
                end
            end
            if (!aw_got && !s_awready) begin
                if (aw_wait == 0) begin
                    s_awready = 1'b1;
                end else begin
                    aw_wait--;
                end
            end
            if (!w_got && !s_wready) begin
                if (w_wait == 0) begin
                    s_wready = 1'b1;
                end else begin
                    w_wait--;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Comparing process
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        arb_pkg::master_idx_t src;
        #(SAMPLE_DLY);
        hold_b  = withhold_b;
        run_s   = resetn;
        aw_hs_s = resetn && s_awvalid && s_awready;
        w_hs_s  = resetn && s_wvalid && s_wready;
        b_hs_s  = resetn && s_bvalid && s_bready;
        if (resetn) begin
            cycle_no++;
            bvalid_seen = bvalid_seen | m_bvalid;
            if (!$onehot0(m_awready) || !$onehot0(m_wready) || !$onehot0(m_bvalid)) begin
                abort_run("More than one master was served in the same cycle");
            end
            check_mask(m_awready & ~batch_mask, '0, "AW ready outside the batch");
            check_mask(m_wready & ~batch_mask, '0, "W ready outside the batch");
            check_mask(m_bvalid & ~batch_mask, '0, "B valid outside the batch");
            if (aw_hs_s) begin
                src = ready_source(m_awready);
                if (exp_aw_q.size() == 0) begin
                    abort_run("The slave accepted an AW that no master was due to send");
                end else begin
                    check_idx(src, exp_aw_q.pop_front(), "AW source master");
                    check_aw(s_awpayload, exp_aw_pl[src], "AW payload");
                    aw_count[src]++;
                    aw_cycle[src] = cycle_no;
                end
            end
            if (w_hs_s) begin
                src = ready_source(m_wready);
                if (exp_w_q.size() == 0) begin
                    abort_run("The slave accepted a W that no master was due to send");
                end else begin
                    check_idx(src, exp_w_q.pop_front(), "W source master");
                    check_w(s_wpayload, exp_w_pl[src], "W payload");
                    w_count[src]++;
                end
            end
            if (|(m_bvalid & m_bready)) begin
                b_count[ready_source(m_bvalid & m_bready)]++;
            end
        end
    end

    initial begin
        void'($urandom(87));
        resetn      = 1'b0;
        m_awvalid   = '0;
        m_awpayload = '0;
        m_wvalid    = '0;
        m_wpayload  = '0;
        m_bready    = '0;
        withhold_b  = 1'b0;
        batch_mask  = '0;
        bvalid_seen = '0;

        repeat (4) @(negedge clk);
        #(SAMPLE_DLY);
        check_reset_outputs("during reset");
        repeat (4) @(negedge clk);
        resetn = 1'b1;
        #(SAMPLE_DLY);
        check_reset_outputs("after reset");
        @(negedge clk);

        // One master at a time
        run_batch(3'b010, 1'b1);
        run_batch(3'b001, 1'b1);
        run_batch(3'b100, 1'b1);

        run_batch(3'b111, 1'b1);

        repeat (NUM_RANDOM) begin
            run_batch(arb_pkg::master_mask_t'($urandom_range(7, 1)), 1'b1);
        end

        // Withheld responses end every grant on the watchdog
        withhold_b = 1'b1;
        run_batch(3'b011, 1'b0);
        withhold_b = 1'b0;
        check_mask(bvalid_seen, '0, "B valid while responses withheld");
        gap = aw_cycle[1] - aw_cycle[0];
        if (gap > `ARB_QUANTUM_CYCLES + 8) begin
            abort_run($sformatf("FAIL at %0d ns: second AW came %0d cycles after the first",
                                $time, gap));
        end
        run_batch(3'b111, 1'b1);

        $display("Verification passed");
        $finish;
    end

endmodule

/* axi_lite_write_arbiter.sv */
`include "arb_macros.svh"

module axi_lite_write_arbiter (
    input  logic                                               clk,
    input  logic                                               resetn,

    // Master side
    input  arb_pkg::master_mask_t                              i_m_awvalid,
    output arb_pkg::master_mask_t                              o_m_awready,
    input  arb_pkg::aw_payload_t [`ARB_NUM_MASTERS-1:0]        i_m_awpayload,
    input  arb_pkg::master_mask_t                              i_m_wvalid,
    output arb_pkg::master_mask_t                              o_m_wready,
    input  arb_pkg::w_payload_t [`ARB_NUM_MASTERS-1:0]         i_m_wpayload,
    output arb_pkg::master_mask_t                              o_m_bvalid,
    input  arb_pkg::master_mask_t                              i_m_bready,

    // Slave side
    output logic                                               o_s_awvalid,
    input  logic                                               i_s_awready,
    output arb_pkg::aw_payload_t                               o_s_awpayload,
    output logic                                               o_s_wvalid,
    input  logic                                               i_s_wready,
    output arb_pkg::w_payload_t                                o_s_wpayload,
    input  logic                                               i_s_bvalid,
    output logic                                               o_s_bready
);

    logic                 grant_active;
    arb_pkg::master_idx_t grant_idx;
    logic                 grant_start;
    logic                 txn_done;
    logic                 timeout;

    write_grant_fsm fsm0 (
        .clk            (clk),
        .resetn         (resetn),
        .i_m_awvalid    (i_m_awvalid),
        .i_m_bready     (i_m_bready),
        .i_s_bvalid     (i_s_bvalid),
        .i_timeout      (timeout),
        .o_m_bvalid     (o_m_bvalid),
        .o_s_bready     (o_s_bready),
        .o_grant_active (grant_active),
        .o_grant_idx    (grant_idx),
        .o_grant_start  (grant_start),
        .o_txn_done     (txn_done)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Forward channels
    ////////////////////////////////////////////////////////////////////////////

    channel_forwarder #(.payload_t(arb_pkg::aw_payload_t)) aw_fwd (
        .clk            (clk),
        .resetn         (resetn),
        .i_grant_active (grant_active),
        .i_grant_start  (grant_start),
        .i_grant_idx    (grant_idx),
        .i_m_valid      (i_m_awvalid),
        .i_m_payload    (i_m_awpayload),
        .o_m_ready      (o_m_awready),
        .o_s_valid      (o_s_awvalid),
        .o_s_payload    (o_s_awpayload),
        .i_s_ready      (i_s_awready)
    );

    channel_forwarder #(.payload_t(arb_pkg::w_payload_t)) w_fwd (
        .clk            (clk),
        .resetn         (resetn),
        .i_grant_active (grant_active),
        .i_grant_start  (grant_start),
        .i_grant_idx    (grant_idx),
        .i_m_valid      (i_m_wvalid),
        .i_m_payload    (i_m_wpayload),
        .o_m_ready      (o_m_wready),
        .o_s_valid      (o_s_wvalid),
        .o_s_payload    (o_s_wpayload),
        .i_s_ready      (i_s_wready)
    );

    quantum_timer timer0 (
        .clk           (clk),
        .resetn        (resetn),
        .i_grant_start (grant_start),
        .i_txn_done    (txn_done),
        .o_timeout     (timeout)
    );

endmodule

/* quantum_timer.sv */
`include "arb_macros.svh"

module quantum_timer (
    input  logic clk,
    input  logic resetn,
    input  logic i_grant_start,
    input  logic i_txn_done,
    output logic o_timeout
);

    localparam int CNT_W = $clog2(`ARB_QUANTUM_CYCLES + 1);

    logic [CNT_W-1:0] count_q;   // Cycles since grant start
    logic             running_q;
    logic             timeout_q;
    logic             last_cycle;

    // Registered strobe lands exactly on the quantum boundary
    assign last_cycle = running_q && (count_q == CNT_W'(`ARB_QUANTUM_CYCLES - 1));

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            count_q   <= '0;
            running_q <= 1'b0;
            timeout_q <= 1'b0;
        end else begin
            timeout_q <= 1'b0;
            if (i_grant_start) begin
                // New grant restarts the count
                count_q   <= CNT_W'(1);
                running_q <= 1'b1;
            end else if (i_txn_done) begin
                running_q <= 1'b0; // Response arrived in time
            end else if (last_cycle) begin
                running_q <= 1'b0;
                timeout_q <= 1'b1;
            end else if (running_q) begin
                count_q <= count_q + CNT_W'(1);
            end
        end
    end

    assign o_timeout = timeout_q;

endmodule

/* channel_forwarder.sv */
`include "arb_macros.svh"

module channel_forwarder #(
    parameter type payload_t = arb_pkg::aw_payload_t
) (
    input  logic                                clk,
    input  logic                                resetn,
    input  logic                                i_grant_active,
    input  logic                                i_grant_start,
    input  arb_pkg::master_idx_t                i_grant_idx,
    input  arb_pkg::master_mask_t               i_m_valid,
    input  payload_t [`ARB_NUM_MASTERS-1:0]     i_m_payload,
    output arb_pkg::master_mask_t               o_m_ready,
    output logic                                o_s_valid,
    output payload_t                            o_s_payload,
    input  logic                                i_s_ready
);

    arb_pkg::master_mask_t sel;
    logic                  done_q;
    logic                  done_eff;
    logic                  open;
    logic                  hs;

    // One-hot of the granted master
    always_comb begin
        sel = '0;
        for (int i = 0; i < `ARB_NUM_MASTERS; i++) begin
            sel[i] = i_grant_active && (i_grant_idx == arb_pkg::master_idx_t'(i));
        end
    end

    // A flag left over from the previous grant does not count in its first cycle
    assign done_eff = done_q & ~i_grant_start;
    assign open     = ~done_eff;

    always_comb begin
        o_s_payload = '0;
        for (int i = 0; i < `ARB_NUM_MASTERS; i++) begin
            if (sel[i]) begin
                o_s_payload = i_m_payload[i];
            end
        end
    end

    assign o_s_valid = open & |(sel & i_m_valid);
    assign o_m_ready = sel & {`ARB_NUM_MASTERS{open & i_s_ready}};
    assign hs        = o_s_valid & i_s_ready;

    ////////////////////////////////////////////////////////////////////////////
    // One transfer per grant
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            done_q <= 1'b0;
        end else if (i_grant_start) begin
            done_q <= hs; // Handshake in the first cycle still counts
        end else if (hs) begin
            done_q <= 1'b1;
        end
    end

endmodule

/* write_grant_fsm.sv */
`include "arb_macros.svh"

module write_grant_fsm (
    input  logic                  clk,
    input  logic                  resetn,
    input  arb_pkg::master_mask_t i_m_awvalid,
    input  arb_pkg::master_mask_t i_m_bready,
    input  logic                  i_s_bvalid,
    input  logic                  i_timeout,
    output arb_pkg::master_mask_t o_m_bvalid,
    output logic                  o_s_bready,
    output logic                  o_grant_active,
    output arb_pkg::master_idx_t  o_grant_idx,
    output logic                  o_grant_start,
    output logic                  o_txn_done
);

    arb_pkg::master_mask_t snap_q;    // Masters still waiting in this pass
    arb_pkg::master_mask_t grant_oh;
    arb_pkg::master_mask_t remain;
    arb_pkg::master_idx_t  grant_idx_q;
    logic                  grant_active_q;
    logic                  grant_start_q;
    logic                  b_hs;
    logic                  retire;

    // Lowest set bit wins, giving ascending order within a pass
    function automatic arb_pkg::master_idx_t lowest_idx(input arb_pkg::master_mask_t mask);
        arb_pkg::master_idx_t idx;
        idx = '0;
        for (int i = `ARB_NUM_MASTERS - 1; i >= 0; i--) begin
            if (mask[i]) begin
                idx = arb_pkg::master_idx_t'(i);
            end
        end
        return idx;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // B response routing
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        grant_oh = '0;
        for (int i = 0; i < `ARB_NUM_MASTERS; i++) begin
            grant_oh[i] = grant_active_q && (grant_idx_q == arb_pkg::master_idx_t'(i));
        end
    end

    assign o_m_bvalid = grant_oh & {`ARB_NUM_MASTERS{i_s_bvalid}};
    assign o_s_bready = |(grant_oh & i_m_bready);

    assign b_hs   = i_s_bvalid & o_s_bready;
    assign retire = b_hs | (grant_active_q & i_timeout);
    assign remain = snap_q & ~grant_oh;

    ////////////////////////////////////////////////////////////////////////////
    // Snapshot and grant sequencing
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            snap_q         <= '0;
            grant_active_q <= 1'b0;
            grant_idx_q    <= '0;
            grant_start_q  <= 1'b0;
        end else begin
            grant_start_q <= 1'b0;
            if (!grant_active_q) begin
                // Idle, take a snapshot of every requester
                if (|i_m_awvalid) begin
                    snap_q         <= i_m_awvalid;
                    grant_active_q <= 1'b1;
                    grant_idx_q    <= lowest_idx(i_m_awvalid);
                    grant_start_q  <= 1'b1;
                end
            end else if (retire) begin
                snap_q <= remain;
                if (|remain) begin
                    grant_idx_q   <= lowest_idx(remain); // Next in line, no gap
                    grant_start_q <= 1'b1;
                end else begin
                    grant_active_q <= 1'b0; // Pass exhausted
                end
            end
        end
    end

    assign o_grant_active = grant_active_q;
    assign o_grant_idx    = grant_idx_q;
    assign o_grant_start  = grant_start_q;
    assign o_txn_done     = b_hs;

endmodule

/* arb_pkg.sv */
`include "arb_macros.svh"

package arb_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Master indexing
    ////////////////////////////////////////////////////////////////////////////

    // Index of one master
    typedef logic [1:0] master_idx_t;

    // One bit per master
    typedef logic [`ARB_NUM_MASTERS-1:0] master_mask_t;

    ////////////////////////////////////////////////////////////////////////////
    // Forward channel payloads
    ////////////////////////////////////////////////////////////////////////////

    // Write address channel, 35 bits
    typedef struct packed {
        logic [`ARB_ADDR_WIDTH-1:0] addr;
        logic [`ARB_PROT_WIDTH-1:0] prot;
    } aw_payload_t;

    // Write data channel, 36 bits
    typedef struct packed {
        logic [`ARB_DATA_WIDTH-1:0]   data;
        logic [`ARB_DATA_WIDTH/8-1:0] strb; // One bit per data byte
    } w_payload_t;

endpackage

/* arb_macros.svh */
`ifndef ARB_MACROS_SVH
`define ARB_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// Arbiter sizing
////////////////////////////////////////////////////////////////////////////

// Masters sharing the slave
`define ARB_NUM_MASTERS 3

// AXI4-Lite field widths
`define ARB_ADDR_WIDTH 32
`define ARB_DATA_WIDTH 32
`define ARB_PROT_WIDTH 3

// Cycles a grant may wait for its B response
`define ARB_QUANTUM_CYCLES 16

`endif
